/* sim.f */
+incdir+src
+incdir+sim
src/snow_pkg.sv
src/snow_decode.sv
src/snow_execute.sv
src/snow_result.sv
src/snow_top.sv
sim/tb_snow.sv

/* run_sim.sh */
#!/bin/sh
# Builds the snowflake testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_snow \
    -Mdir obj_dir -o sim_snow
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_snow > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    echo "Failures found in sim.log"
    exit 1
fi

echo "Simulation log is clean"
exit 0

/* sim/tb_programs.svh */
// Hand-assembled test programs for the snowflake testbench
// Included inside the testbench module, each image padded with zeros

`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int PROG_DOUBLER = 0;
localparam int PROG_ARITH   = 1;
localparam int PROG_SUM     = 2;
localparam int PROG_MEMORY  = 3;
localparam int PROG_WORDS   = 16;

localparam logic [31:0] PROG_IMAGE [4][PROG_WORDS] = '{
    // Doubler: lw x1,arg / addi x2,x0,1 / beq x1,x0,+16 / add x2,x2,x2
    // addi x1,x1,-1 / jal x0,-12 / sw x2,result / sw x0,done / jal x0,0
    '{32'h4040_2083, 32'h0010_0113, 32'h0000_8863, 32'h0021_0133,
      32'hfff0_8093, 32'hff5f_f06f, 32'h4020_2423, 32'h4000_2023,
      32'h0000_006f, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
      32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
    // Arithmetic mix: lw x1 / slli x2,x1,3 / add x2,x2,x1 / addi x4,x0,0x55
    // xor x2,x2,x4 / addi x5,x0,9 / sub x2,x2,x5 / addi x6,x0,100
    // slt x7,x2,x6 / sw x2,result / sw x7,0x40 / sw x0,done / jal x0,0
    '{32'h4040_2083, 32'h0030_9113, 32'h0011_0133, 32'h0550_0213,
      32'h0041_4133, 32'h0090_0293, 32'h4051_0133, 32'h0640_0313,
      32'h0061_23b3, 32'h4020_2423, 32'h0470_2023, 32'h4000_2023,
      32'h0000_006f, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
    // Sum loop: lw x1 / addi x2,x0,0 / addi x3,x0,0 / addi x3,x3,1
    // add x2,x2,x3 / blt x3,x1,-8 / bne x3,x1,+8 / bne x2,x0,+8
    // addi x2,x2,1000 (must be skipped) / sw x2,result / sw x0,done / jal x0,0
    '{32'h4040_2083, 32'h0000_0113, 32'h0000_0193, 32'h0011_8193,
      32'h0031_0133, 32'hfe11_cce3, 32'h0011_9463, 32'h0001_1463,
      32'h3e81_0113, 32'h4020_2423, 32'h4000_2023, 32'h0000_006f,
      32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
    // Memory round trip: lw x1 / sw x1,0x20 / lw x2,0x20 / addi x3,x2,1
    // sw x3,result / sw x0,done / jal x0,0
    '{32'h4040_2083, 32'h0210_2023, 32'h0200_2103, 32'h0011_0193,
      32'h4030_2423, 32'h4000_2023, 32'h0000_006f, 32'h0000_0000,
      32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
      32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000}
};

`endif

/* sim/tb_snow.sv */
// Testbench for the snowflake core: loads each program, runs it to done
// and compares the result word with the value given by the program's rule

`timescale 1ns/100ps

`include "snow_config.svh"

module tb_snow;

    localparam int LA          = $clog2(`SNOW_IMEM_WORDS);
    localparam int N_TESTS     = 11;
    localparam int DONE_LIMIT  = 4096;
    localparam int WATCH_LIMIT = N_TESTS * 4200;

    `include "tb_programs.svh"

    typedef struct {
        string       name;
        int          prog;
        logic [31:0] arg;
        logic [31:0] expected;
        int          abort_cycles;
    } test_t;

    logic          clk;
    logic          rst;
    logic          load_en;
    logic [LA-1:0] load_addr;
    logic [31:0]   load_data;
    logic [31:0]   arg;
    logic [31:0]   result;
    logic          done;

    test_t tests [N_TESTS];
    int    pass_count;
    int    fail_count;
    logic  reset_bad;

    snow_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .arg       (arg),
        .result    (result),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reference rules of the four programs
    function automatic logic [31:0] expected_result(input int prog, input logic [31:0] a);
        logic [31:0] v;
        case (prog)
            PROG_DOUBLER: v = 32'd1 << a;
            PROG_ARITH:   v = (((a << 3) + a) ^ 32'h55) - 32'd9;
            PROG_SUM:     v = (a * (a + 32'd1)) / 32'd2;
            default:      v = a + 32'd1;
        endcase
        return v;
    endfunction

    task automatic add_test(input int idx, input string name, input int prog,
                            input logic [31:0] a, input int abort_cycles);
        tests[idx].name         = name;
        tests[idx].prog         = prog;
        tests[idx].arg          = a;
        tests[idx].expected     = expected_result(prog, a);
        tests[idx].abort_cycles = abort_cycles;
    endtask

    // Reset, program load and release with the test's argument
    task automatic start_program(input int t);
        int i;
        @(posedge clk);
        rst     <= 1'b1;
        load_en <= 1'b0;
        repeat (10) @(posedge clk);
        for (i = 0; i < PROG_WORDS; i++) begin
            load_en   <= 1'b1;
            load_addr <= LA'(i);
            load_data <= PROG_IMAGE[tests[t].prog][i];
            @(posedge clk);
        end
        load_en <= 1'b0;
        @(negedge clk);
        if (done !== 1'b0) begin
            $display("ERROR %s: done after reset expected 0, actual %b", tests[t].name, done);
            reset_bad = 1'b1;
        end
        if (result !== 32'd0) begin
            $display("ERROR %s: result after reset expected 0x%08h, actual 0x%08h",
                     tests[t].name, 32'd0, result);
            reset_bad = 1'b1;
        end
        @(posedge clk);
        arg <= tests[t].arg;
        rst <= 1'b0;
    endtask

    task automatic wait_done(output bit seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
            seen = (done === 1'b1);
        end
    endtask

    task automatic run_test(input int t);
        bit seen;
        reset_bad = 1'b0;
        if (tests[t].abort_cycles > 0) begin
            // Partial run, cut short by the reset of the full run
            start_program(t);
            repeat (tests[t].abort_cycles) @(posedge clk);
        end
        start_program(t);
        wait_done(seen);
        if (!seen) begin
            $display("TIMEOUT %s: done never rose within %0d cycles", tests[t].name, DONE_LIMIT);
            fail_count++;
        end else if (result !== tests[t].expected) begin
            $display("ERROR %s: expected 0x%08h, actual 0x%08h",
                     tests[t].name, tests[t].expected, result);
            fail_count++;
        end else if (reset_bad) begin
            $display("%s: result correct but the state after reset was wrong", tests[t].name);
            fail_count++;
        end else begin
            $display("ok %s: result 0x%08h", tests[t].name, result);
            pass_count++;
        end
    endtask

    // ========================================================================
    // Test table and main sequence
    // ========================================================================

    initial begin
        logic [31:0] rand_arg;
        int          t;
        rst        = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        arg        = '0;
        pass_count = 0;
        fail_count = 0;
        reset_bad  = 1'b0;
        void'($urandom(32'h7fba_a762));
        rand_arg = 32'd1 + ($urandom % 15);

        add_test(0,  "doubler_1",         PROG_DOUBLER, 32'd1,          0);
        add_test(1,  "doubler_5",         PROG_DOUBLER, 32'd5,          0);
        add_test(2,  "doubler_15",        PROG_DOUBLER, 32'd15,         0);
        add_test(3,  "doubler_random",    PROG_DOUBLER, rand_arg,       0);
        add_test(4,  "arith_7",           PROG_ARITH,   32'd7,          0);
        add_test(5,  "arith_1234",        PROG_ARITH,   32'h1234,       0);
        add_test(6,  "sum_10",            PROG_SUM,     32'd10,         0);
        add_test(7,  "sum_100",           PROG_SUM,     32'd100,        0);
        add_test(8,  "memory_beef",       PROG_MEMORY,  32'h0000_beef,  0);
        add_test(9,  "doubler_mid_reset", PROG_DOUBLER, 32'd15,         60);
        add_test(10, "memory_wrap",       PROG_MEMORY,  32'hffff_ffff,  0);

        for (t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end

        $display("Summary: %0d tests, %0d passed, %0d failed", N_TESTS, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog sized for the longest possible run of every test
    initial begin
        repeat (WATCH_LIMIT) @(posedge clk);
        $display("Watchdog expired: run did not finish within %0d cycles", WATCH_LIMIT);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* src/snow_top.sv */
// Top level of the snowflake core: decode, execute and result units
// Programs are loaded through the load port while rst is held high

`timescale 1ns/100ps

`include "snow_config.svh"

module snow_top import snow_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load_en,
    input  logic [$clog2(`SNOW_IMEM_WORDS)-1:0] load_addr,
    input  logic [31:0]                         load_data,
    input  logic [31:0]                         arg,
    output logic [31:0]                         result,
    output logic                                done
);

    // Decode to execute
    logic        op_valid;
    dec_op_t     op;
    logic        credit_ret;
    logic        redirect;
    logic [31:0] redirect_pc;

    // Execute to result
    commit_t     commit;
    logic [4:0]  rs1_idx;
    logic [4:0]  rs2_idx;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] load_data_fwd;

    snow_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .credit_ret  (credit_ret),
        .op_valid    (op_valid),
        .op          (op)
    );

    snow_execute u_execute (
        .clk           (clk),
        .rst           (rst),
        .op_valid      (op_valid),
        .op            (op),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .load_data_fwd (load_data_fwd),
        .credit_ret    (credit_ret),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .rs1_idx       (rs1_idx),
        .rs2_idx       (rs2_idx),
        .commit        (commit)
    );

    snow_result u_result (
        .clk           (clk),
        .rst           (rst),
        .commit        (commit),
        .arg           (arg),
        .rs1_idx       (rs1_idx),
        .rs2_idx       (rs2_idx),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .load_data_fwd (load_data_fwd),
        .result        (result),
        .done          (done)
    );

endmodule

/* src/snow_result.sv */
// Result unit: register file, data memory and the MMIO words
// Commits ALU values on arrival and load data one cycle later

`timescale 1ns/100ps

`include "snow_config.svh"

module snow_result import snow_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  commit_t     commit,
    input  logic [31:0] arg,
    input  logic [4:0]  rs1_idx,
    input  logic [4:0]  rs2_idx,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    output logic [31:0] load_data_fwd,
    output logic [31:0] result,
    output logic        done
);

    localparam int DA = $clog2(`SNOW_DMEM_WORDS);

    logic [31:0]   regs [32];
    logic [31:0]   dmem [`SNOW_DMEM_WORDS];
    logic [DA-1:0] dmem_idx;
    logic          is_mmio;
    logic          ld_pend;
    logic [4:0]    ld_rd;

    // x0 reads as zero whatever the array holds
    assign rs1_data = (rs1_idx == 5'd0) ? 32'd0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? 32'd0 : regs[rs2_idx];

    assign dmem_idx = commit.addr[DA+1:2];
    assign is_mmio  = commit.addr inside {`SNOW_ADDR_DONE, `SNOW_ADDR_ARG, `SNOW_ADDR_RESULT};

    // ========================================================================
    // Register file and data memory
    // ========================================================================

    always_ff @(posedge clk) begin
        if (commit.valid && !commit.is_load && commit.rd != 5'd0) begin
            regs[commit.rd] <= commit.value;
        end
        if (ld_pend && ld_rd != 5'd0) begin
            regs[ld_rd] <= load_data_fwd;
        end
        if (commit.valid && commit.is_store && !is_mmio) begin
            dmem[dmem_idx] <= commit.store_data;
        end
        if (commit.valid && commit.is_load) begin
            ld_rd         <= commit.rd;
            load_data_fwd <= (commit.addr == `SNOW_ADDR_ARG) ? arg : dmem[dmem_idx];
        end
    end

    // ========================================================================
    // MMIO outputs
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            ld_pend <= 1'b0;
            result  <= '0;
            done    <= 1'b0;
        end else begin
            ld_pend <= commit.valid && commit.is_load;
            if (commit.valid && commit.is_store) begin
                if (commit.addr == `SNOW_ADDR_RESULT) begin
                    result <= commit.store_data;
                end
                // Sticky until the next reset
                if (commit.addr == `SNOW_ADDR_DONE) begin
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

/* src/snow_execute.sv */
// Execute unit: operation queue, forwarding, ALU and branch resolution
// Returns one credit to decode for every queue entry it removes

`timescale 1ns/100ps

`include "snow_config.svh"

module snow_execute import snow_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        op_valid,
    input  dec_op_t     op,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] load_data_fwd,
    output logic        credit_ret,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic [4:0]  rs1_idx,
    output logic [4:0]  rs2_idx,
    output commit_t     commit
);

    localparam int QW = $clog2(`SNOW_QUEUE_DEPTH);
    localparam int CW = $clog2(`SNOW_QUEUE_DEPTH + 1);

    dec_op_t       queue [`SNOW_QUEUE_DEPTH];
    logic [QW-1:0] wr_ptr;
    logic [QW-1:0] rd_ptr;
    logic [CW-1:0] count;
    dec_op_t       head;
    logic          pop;
    logic          issue;
    logic          epoch;
    logic          load_stall;
    logic          ld_fwd;
    logic [4:0]    ld_rd;
    logic [31:0]   src1;
    logic [31:0]   src2;
    logic [31:0]   alu_b;
    logic [31:0]   alu_res;
    logic          taken;
    commit_t       commit_nxt;

    // ========================================================================
    // Queue
    // ========================================================================

    assign head  = queue[rd_ptr];
    assign pop   = (count != '0) && !load_stall;
    assign issue = pop && (head.epoch == epoch);

    // Stale entries are dropped but still hand back their credit
    assign credit_ret = pop;

    always_ff @(posedge clk) begin
        if (op_valid) begin
            queue[wr_ptr] <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (op_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CW'(op_valid) - CW'(pop);
        end
    end

    // ========================================================================
    // Operands with forwarding
    // ========================================================================

    assign rs1_idx = head.rs1;
    assign rs2_idx = head.rs2;

    // Load data wins the cycle after a stall, else the in-flight ALU commit
    function automatic logic [31:0] fwd_sel(input logic [4:0] idx, input logic [31:0] rf);
        logic [31:0] val;
        val = rf;
        if (idx != 5'd0 && ld_fwd && ld_rd == idx) begin
            val = load_data_fwd;
        end else if (idx != 5'd0 && commit.valid && !commit.is_load && commit.rd == idx) begin
            val = commit.value;
        end
        return val;
    endfunction

    assign src1  = fwd_sel(head.rs1, rs1_data);
    assign src2  = fwd_sel(head.rs2, rs2_data);
    assign alu_b = head.use_imm ? head.imm : src2;

    always_comb begin
        case (head.alu_op)
            ALU_SUB:    alu_res = src1 - alu_b;
            ALU_SLL:    alu_res = src1 << alu_b[4:0];
            ALU_AND:    alu_res = src1 & alu_b;
            ALU_OR:     alu_res = src1 | alu_b;
            ALU_XOR:    alu_res = src1 ^ alu_b;
            ALU_SLT:    alu_res = {31'b0, $signed(src1) < $signed(alu_b)};
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = src1 + alu_b;
        endcase
    end

    // ========================================================================
    // Branches and commit
    // ========================================================================

    always_comb begin
        case (head.branch)
            BR_EQ:   taken = src1 == src2;
            BR_NE:   taken = src1 != src2;
            BR_LT:   taken = $signed(src1) < $signed(src2);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // Not-taken path is already the sequential fetch stream
    assign redirect    = issue && taken;
    assign redirect_pc = head.pc + head.imm;

    always_comb begin
        commit_nxt.valid      = issue;
        commit_nxt.rd         = head.writes_rd ? head.rd : 5'd0;
        commit_nxt.value      = (head.branch == BR_JAL) ? head.pc + 32'd4 : alu_res;
        commit_nxt.addr       = alu_res[11:0];
        commit_nxt.store_data = src2;
        commit_nxt.is_load    = issue && head.is_load;
        commit_nxt.is_store   = issue && head.is_store;
    end

    always_ff @(posedge clk) begin
        if (issue && head.is_load) begin
            ld_rd <= head.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit     <= '0;
            epoch      <= 1'b0;
            load_stall <= 1'b0;
            ld_fwd     <= 1'b0;
        end else begin
            commit     <= commit_nxt;
            load_stall <= issue && head.is_load;
            ld_fwd     <= load_stall;
            if (redirect) begin
                epoch <= ~epoch;
            end
        end
    end

endmodule

/* src/snow_decode.sv */
// Fetch and decode unit: PC, instruction memory and credit-limited issue
// Sends decoded operations to execute, tagged with the current epoch

`timescale 1ns/100ps

`include "snow_config.svh"

module snow_decode import snow_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load_en,
    input  logic [$clog2(`SNOW_IMEM_WORDS)-1:0] load_addr,
    input  logic [31:0]                         load_data,
    input  logic                                redirect,
    input  logic [31:0]                         redirect_pc,
    input  logic                                credit_ret,
    output logic                                op_valid,
    output dec_op_t                             op
);

    localparam int IA = $clog2(`SNOW_IMEM_WORDS);
    localparam int CW = $clog2(`SNOW_QUEUE_DEPTH + 1);

    logic [31:0]   imem [`SNOW_IMEM_WORDS];
    logic [31:0]   pc;
    logic [31:0]   fetch_pc;
    instr_u        fetch_word;
    logic          fetch_valid;
    logic          fetch_en;
    logic          epoch;
    logic [CW-1:0] credit_cnt;
    dec_op_t       dec;

    // A credit is reserved for every word already in the decode pipe
    assign fetch_en = credit_cnt > (CW'(fetch_valid) + CW'(op_valid));

    // Program load port and synchronous fetch
    always_ff @(posedge clk) begin
        if (rst && load_en) begin
            imem[load_addr] <= load_data;
        end
        if (fetch_en) begin
            fetch_word <= imem[pc[IA+1:2]];
            fetch_pc   <= pc;
        end
        op <= dec;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= '0;
            epoch       <= 1'b0;
            fetch_valid <= 1'b0;
            op_valid    <= 1'b0;
            credit_cnt  <= CW'(`SNOW_QUEUE_DEPTH);
        end else begin
            credit_cnt <= credit_cnt + CW'(credit_ret) - CW'(op_valid);
            op_valid   <= fetch_valid && !redirect;
            if (redirect) begin
                // Word being fetched belongs to the old path
                pc          <= redirect_pc;
                epoch       <= ~epoch;
                fetch_valid <= 1'b0;
            end else begin
                fetch_valid <= fetch_en;
                if (fetch_en) begin
                    pc <= pc + 32'd4;
                end
            end
        end
    end

    // ========================================================================
    // Decoder
    // ========================================================================

    always_comb begin
        dec           = '0;
        dec.pc        = fetch_pc;
        dec.epoch     = epoch;
        dec.rs1       = fetch_word.r.rs1;
        dec.rs2       = fetch_word.r.rs2;
        dec.rd        = fetch_word.r.rd;
        dec.alu_op    = ALU_ADD;
        dec.branch    = BR_NONE;
        case (fetch_word.r.opcode)
            OP_LUI: begin
                dec.imm       = {fetch_word.u.imm, 12'b0};
                dec.alu_op    = ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OP_IMM: begin
                dec.imm       = {{20{fetch_word.i.imm[11]}}, fetch_word.i.imm};
                dec.use_imm   = 1'b1;
                dec.writes_rd = fetch_word.i.funct3 inside {3'b000, 3'b001};
                if (fetch_word.i.funct3 == 3'b001) begin
                    dec.alu_op = ALU_SLL;
                end
            end
            OP_REG: begin
                dec.writes_rd = 1'b1;
                case (fetch_word.r.funct3)
                    3'b000:  dec.alu_op = fetch_word.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  dec.alu_op = ALU_SLL;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: dec.writes_rd = 1'b0;
                endcase
            end
            OP_BRANCH: begin
                dec.imm = {{19{fetch_word.b.imm12}}, fetch_word.b.imm12, fetch_word.b.imm11,
                           fetch_word.b.imm10_5, fetch_word.b.imm4_1, 1'b0};
                case (fetch_word.b.funct3)
                    3'b000:  dec.branch = BR_EQ;
                    3'b001:  dec.branch = BR_NE;
                    3'b100:  dec.branch = BR_LT;
                    default: dec.branch = BR_NONE;
                endcase
            end
            OP_JAL: begin
                // J-type bits sit in the U-type immediate field
                dec.imm = {{11{fetch_word.u.imm[19]}}, fetch_word.u.imm[19],
                           fetch_word.u.imm[7:0], fetch_word.u.imm[8],
                           fetch_word.u.imm[18:9], 1'b0};
                dec.branch    = BR_JAL;
                dec.writes_rd = 1'b1;
            end
            OP_LOAD: begin
                dec.imm       = {{20{fetch_word.i.imm[11]}}, fetch_word.i.imm};
                dec.use_imm   = 1'b1;
                dec.is_load   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OP_STORE: begin
                dec.imm      = {{20{fetch_word.s.imm_hi[6]}}, fetch_word.s.imm_hi,
                                fetch_word.s.imm_lo};
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* src/snow_pkg.sv */
// Shared types of the snowflake core: opcodes, instruction formats and
// the records passed from decode to execute and from execute to result

package snow_pkg;

    // ========================================================================
    // Encodings
    // ========================================================================

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_JAL
    } branch_e;

    // ========================================================================
    // Instruction formats
    // ========================================================================

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    // Also carries the scrambled JAL immediate in imm
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
    } instr_u;

    // ========================================================================
    // Inter-unit records
    // ========================================================================

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        alu_op_e     alu_op;
        branch_e     branch;
        logic        use_imm;
        logic        is_load;
        logic        is_store;
        logic        writes_rd;
        logic        epoch;
    } dec_op_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] value;
        logic [11:0] addr;
        logic [31:0] store_data;
        logic        is_load;
        logic        is_store;
    } commit_t;

endpackage

/* src/snow_config.svh */
// Build-time sizes and memory-mapped addresses for the snowflake core
// Included by every RTL unit that sizes a memory or decodes an address

`ifndef SNOW_CONFIG_SVH
`define SNOW_CONFIG_SVH

// Memory depths in 32-bit words
`define SNOW_IMEM_WORDS 256
`define SNOW_DMEM_WORDS 256

// Execute queue depth, also the decode credit count
`define SNOW_QUEUE_DEPTH 4

// MMIO words, 12-bit byte addresses
`define SNOW_ADDR_DONE   12'h400
`define SNOW_ADDR_ARG    12'h404
`define SNOW_ADDR_RESULT 12'h408

`endif
